/* verilog/oled_pkg.sv */
package oled_pkg;

	// ******************************
	// panel geometry
	// ******************************
	localparam int PANEL_WIDTH = 96;
	localparam int PANEL_HEIGHT = 64;
	localparam int PIXEL_COUNT = PANEL_WIDTH * PANEL_HEIGHT;
	localparam int INDEX_W = 13;    // enough for indices 0 to 6143.

	// ******************************
	// colour word
	// ******************************
	typedef struct packed
	{
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	typedef union packed
	{
		logic [15:0] raw;    // compared against colour keys.
		rgb565_t rgb;        // used when channels are scaled.
	} pixel_colour_t;

	localparam logic [15:0] TRANSPARENT_KEY = 16'h0000;    // black sprite entries are see-through.
	localparam logic [15:0] BACKDROP_COLOUR = 16'h0010;
	localparam logic [15:0] BAR_COLOUR = 16'h07E0;
	localparam logic [15:0] LOW_BAR_COLOUR = 16'hF800;

	// ******************************
	// status bar
	// ******************************
	localparam int BAR_ROW_FIRST = 58;
	localparam int BAR_ROW_LAST = 61;
	localparam int LOW_LEVEL = 24;    // levels below this blink red.
	localparam int BLINK_FRAMES = 16;
	localparam int LEVEL_W = 7;
	localparam int FRAME_COUNT_W = 5;    // one bit above the blink period.

endpackage

/* verilog/layer_if.sv */
`timescale 1ns/100ps

interface layer_if;
	import oled_pkg::*;

	logic valid;
	logic [INDEX_W-1:0] index;    // the pixel this result belongs to.
	pixel_colour_t colour;
	logic opaque;    // low lets the layer below show through.

	modport layer
	(
		output valid,
		output index,
		output colour,
		output opaque
	);

	modport compositor
	(
		input valid,
		input index,
		input colour,
		input opaque
	);

endinterface

/* verilog/injury_icon_layer.sv */
`timescale 1ns/100ps

module injury_icon_layer
(
	input logic clk,
	input logic rst,
	input logic pixel_valid,
	input logic [oled_pkg::INDEX_W-1:0] pixel_index,
	layer_if.layer layer
);
	import oled_pkg::*;

	pixel_colour_t entry;

	// ******************************
	// sprite table, rows 22 to 45
	// ******************************
	always_comb
	begin
		case (pixel_index)
			13'd2159: entry.raw = 16'hFFBF;    // top edge of the icon.
			13'd2160: entry.raw = 16'hF6DA;
			13'd2161: entry.raw = 16'hE674;
			13'd2162: entry.raw = 16'hFF9F;
			13'd2250: entry.raw = 16'hE6BB;
			13'd2253: entry.raw = 16'hEE77;
			13'd2256: entry.raw = 16'hD5AC;
			13'd2259: entry.raw = 16'hF6F7;
			13'd2344: entry.raw = 16'hDE39;
			13'd2348: entry.raw = 16'hFEB5;
			13'd2352: entry.raw = 16'hDE49;
			13'd2356: entry.raw = 16'hEE8A;
			13'd2438: entry.raw = 16'hDE59;
			13'd2443: entry.raw = 16'hDBC9;
			13'd2448: entry.raw = 16'hEE66;
			13'd2453: entry.raw = 16'hE5CD;
			13'd2533: entry.raw = 16'hDE38;
			13'd2539: entry.raw = 16'hDCAE;
			13'd2544: entry.raw = 16'hC4AB;
			13'd2549: entry.raw = 16'hEDE8;
			13'd2629: entry.raw = 16'hE678;
			13'd2635: entry.raw = 16'h7B26;
			13'd2640: entry.raw = 16'hCC8E;
			13'd2645: entry.raw = 16'hC42D;
			13'd2725: entry.raw = 16'hE679;
			13'd2730: entry.raw = 16'h1221;    // dark wound centre.
			13'd2735: entry.raw = 16'hCDB0;
			13'd2740: entry.raw = 16'hE571;
			13'd2821: entry.raw = 16'hF79F;
			13'd2826: entry.raw = 16'h4AC4;
			13'd2831: entry.raw = 16'hAD11;
			13'd2836: entry.raw = 16'hCC4D;
			13'd2918: entry.raw = 16'h840C;
			13'd2923: entry.raw = 16'h7CEE;
			13'd2928: entry.raw = 16'hF75D;
			13'd2933: entry.raw = 16'hCCF1;
			13'd3014: entry.raw = 16'h8D32;
			13'd3019: entry.raw = 16'hCDD1;
			13'd3024: entry.raw = 16'hDE79;
			13'd3030: entry.raw = 16'hE5F3;
			13'd3110: entry.raw = 16'hE73C;
			13'd3115: entry.raw = 16'h8C0A;
			13'd3120: entry.raw = 16'h748E;
			13'd3126: entry.raw = 16'hF6B5;
			13'd3206: entry.raw = 16'hF6FB;
			13'd3211: entry.raw = 16'h640C;
			13'd3216: entry.raw = 16'hC6F5;
			13'd3221: entry.raw = 16'hEE32;
			13'd3302: entry.raw = 16'hCE38;
			13'd3307: entry.raw = 16'h9CCF;
			13'd3312: entry.raw = 16'hF7FA;
			13'd3317: entry.raw = 16'hFFBA;
			13'd3398: entry.raw = 16'hF7BE;
			13'd3402: entry.raw = 16'hDE92;
			13'd3407: entry.raw = 16'h8CED;
			13'd3412: entry.raw = 16'hD4CF;
			13'd3496: entry.raw = 16'h5C2C;
			13'd3499: entry.raw = 16'hA46E;
			13'd3504: entry.raw = 16'hDD30;
			13'd3508: entry.raw = 16'hE679;
			13'd3591: entry.raw = 16'hF79E;
			13'd3594: entry.raw = 16'h546C;
			13'd3599: entry.raw = 16'h42C4;
			13'd3602: entry.raw = 16'h53CA;
			13'd3687: entry.raw = 16'hCE17;
			13'd3690: entry.raw = 16'h3325;
			13'd3695: entry.raw = 16'h3A62;
			13'd3698: entry.raw = 16'h5AE6;
			13'd3783: entry.raw = 16'hC616;
			13'd3785: entry.raw = 16'h6C4D;
			13'd3791: entry.raw = 16'h6BA9;
			13'd3793: entry.raw = 16'h42E4;
			13'd3879: entry.raw = 16'hEF5D;
			13'd3881: entry.raw = 16'h640B;
			13'd3887: entry.raw = 16'hBD13;
			13'd3889: entry.raw = 16'hB40C;
			13'd3976: entry.raw = 16'hAC0C;
			13'd3978: entry.raw = 16'hCE38;
			13'd3984: entry.raw = 16'h69E1;
			13'd3986: entry.raw = 16'hE6FC;
			13'd4072: entry.raw = 16'h9B89;
			13'd4074: entry.raw = 16'hC5B5;
			13'd4080: entry.raw = 16'h7AE6;
			13'd4082: entry.raw = 16'hC42D;
			13'd4167: entry.raw = 16'hCDD6;
			13'd4169: entry.raw = 16'hA369;
			13'd4177: entry.raw = 16'hDD94;
			13'd4179: entry.raw = 16'hC46F;
			13'd4263: entry.raw = 16'hC4F2;
			13'd4264: entry.raw = 16'hD46C;
			13'd4265: entry.raw = 16'hC3EB;
			13'd4266: entry.raw = 16'hAC0E;
			13'd4359: entry.raw = 16'hF73C;    // bottom edge of the icon.
			13'd4360: entry.raw = 16'hEE99;
			13'd4361: entry.raw = 16'hEEB9;
			13'd4362: entry.raw = 16'hEEFB;
			default: entry.raw = TRANSPARENT_KEY;
		endcase
	end

	// ******************************
	// output register
	// ******************************
	always_ff @(posedge clk)
	begin
		if (rst)
			layer.valid <= 1'b0;
		else
			layer.valid <= pixel_valid;
		layer.index <= pixel_index;
		layer.colour <= entry;
		layer.opaque <= (entry.raw != TRANSPARENT_KEY);
	end

endmodule

/* verilog/status_bar_layer.sv */
`timescale 1ns/100ps

module status_bar_layer
(
	input logic clk,
	input logic rst,
	input logic pixel_valid,
	input logic [oled_pkg::INDEX_W-1:0] pixel_index,
	input logic level_load,
	input logic [oled_pkg::LEVEL_W-1:0] level_value,
	layer_if.layer layer
);
	import oled_pkg::*;

	logic [LEVEL_W-1:0] level;
	logic [FRAME_COUNT_W-1:0] frame_count;
	logic [INDEX_W-1:0] row;
	logic [LEVEL_W-1:0] col;
	logic level_low;
	logic blink_off;
	logic in_bar;

	always_comb
	begin
		row = pixel_index / INDEX_W'(PANEL_WIDTH);
		col = LEVEL_W'(pixel_index % INDEX_W'(PANEL_WIDTH));
		level_low = (level < LEVEL_W'(LOW_LEVEL));
		blink_off = level_low && frame_count[$clog2(BLINK_FRAMES)];    // dark half of the blink.
		in_bar = (pixel_index < INDEX_W'(PIXEL_COUNT))
			&& (row >= INDEX_W'(BAR_ROW_FIRST))
			&& (row <= INDEX_W'(BAR_ROW_LAST))
			&& (col < level);
	end

	// ******************************
	// level and frame state
	// ******************************
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			level <= LEVEL_W'(PANEL_WIDTH);
			frame_count <= '0;
		end
		else
		begin
			if (level_load)
				level <= (level_value > LEVEL_W'(PANEL_WIDTH)) ? LEVEL_W'(PANEL_WIDTH) : level_value;
			if (pixel_valid && pixel_index == '0)
				frame_count <= frame_count + 1'b1;    // index 0 marks a new frame.
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			layer.valid <= 1'b0;
		else
			layer.valid <= pixel_valid;
		layer.index <= pixel_index;
		layer.colour.raw <= level_low ? LOW_BAR_COLOUR : BAR_COLOUR;
		layer.opaque <= in_bar && !blink_off;
	end

endmodule

/* verilog/pixel_compositor.sv */
`timescale 1ns/100ps

module pixel_compositor
(
	input logic clk,
	input logic rst,
	input logic pause,
	layer_if.compositor icon,
	layer_if.compositor bar,
	output logic oled_valid,
	output logic [oled_pkg::INDEX_W-1:0] oled_index,
	output oled_pkg::pixel_colour_t oled_colour
);
	import oled_pkg::*;

	pixel_colour_t merged;
	pixel_colour_t shown;
	logic bar_hit;

	// ******************************
	// layer priority
	// ******************************
	always_comb
	begin
		bar_hit = bar.valid && bar.opaque && (bar.index == icon.index);    // same pixel only.
		if (icon.opaque)
			merged = icon.colour;
		else if (bar_hit)
			merged = bar.colour;
		else
			merged.raw = BACKDROP_COLOUR;
	end

	// pause halves every channel.
	always_comb
	begin
		shown = merged;
		if (pause)
		begin
			shown.rgb.r = {1'b0, merged.rgb.r[4:1]};
			shown.rgb.g = {1'b0, merged.rgb.g[5:1]};
			shown.rgb.b = {1'b0, merged.rgb.b[4:1]};
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			oled_valid <= 1'b0;
		else
			oled_valid <= icon.valid;    // both layers run in step.
		oled_index <= icon.index;
		oled_colour <= shown;
	end

endmodule

/* verilog/oled_overlay_top.sv */
`timescale 1ns/100ps

module oled_overlay_top
(
	input logic clk,
	input logic rst,
	input logic pixel_valid,
	input logic [oled_pkg::INDEX_W-1:0] pixel_index,
	input logic level_load,
	input logic [oled_pkg::LEVEL_W-1:0] level_value,
	input logic pause,
	output logic oled_valid,
	output logic [oled_pkg::INDEX_W-1:0] oled_index,
	output logic [15:0] oled_colour
);

	layer_if icon_layer ();
	layer_if bar_layer ();

	injury_icon_layer i_icon
	(
		.clk(clk),
		.rst(rst),
		.pixel_valid(pixel_valid),
		.pixel_index(pixel_index),
		.layer(icon_layer.layer)
	);

	status_bar_layer i_bar
	(
		.clk(clk),
		.rst(rst),
		.pixel_valid(pixel_valid),
		.pixel_index(pixel_index),
		.level_load(level_load),
		.level_value(level_value),
		.layer(bar_layer.layer)
	);

	pixel_compositor i_compositor
	(
		.clk(clk),
		.rst(rst),
		.pause(pause),
		.icon(icon_layer.compositor),
		.bar(bar_layer.compositor),
		.oled_valid(oled_valid),
		.oled_index(oled_index),
		.oled_colour(oled_colour)
	);

endmodule

/* tests/oled_overlay_tb.sv */
`timescale 1ns/100ps

module oled_overlay_tb;
	import oled_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000;    // far above the few hundred cycles the tests need.
	localparam int DRAIN_LIMIT = 8;

	logic clk;
	logic rst;
	logic pixel_valid;
	logic [INDEX_W-1:0] pixel_index;
	logic level_load;
	logic [LEVEL_W-1:0] level_value;
	logic pause;
	logic oled_valid;
	logic [INDEX_W-1:0] oled_index;
	logic [15:0] oled_colour;

	int cycle_count = 0;
	int model_level;
	int model_frames;    // index-0 pixels sent so far.
	string test_name;
	int exp_index_q[$];
	logic [15:0] exp_colour_q[$];
	int exp_cycle_q[$];

	oled_overlay_top i_dut
	(
		.clk(clk),
		.rst(rst),
		.pixel_valid(pixel_valid),
		.pixel_index(pixel_index),
		.level_load(level_load),
		.level_value(level_value),
		.pause(pause),
		.oled_valid(oled_valid),
		.oled_index(oled_index),
		.oled_colour(oled_colour)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ******************************
	// failure reporting and checks
	// ******************************
	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			report_failure($sformatf("mismatch in %s: expected 0x%0h, actual 0x%0h",
				name, expected, actual));
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_failure($sformatf("run timed out after %0d cycles", cycle_count));
	end

	// ******************************
	// reference model
	// ******************************
	function automatic logic [15:0] expected_colour(input int idx);
		int row;
		int col;
		logic low;
		logic blink_phase;
		logic [15:0] icon;
		logic [15:0] c;
		row = idx / PANEL_WIDTH;
		col = idx % PANEL_WIDTH;
		low = (model_level < LOW_LEVEL);
		blink_phase = ((model_frames / BLINK_FRAMES) % 2) == 1;
		case (idx)
			2159: icon = 16'hFFBF;
			2730: icon = 16'h1221;
			3984: icon = 16'h69E1;
			default: icon = 16'h0000;    // everything else the tests touch is black.
		endcase
		if (icon != TRANSPARENT_KEY)
			c = icon;
		else if (row >= BAR_ROW_FIRST && row <= BAR_ROW_LAST && col < model_level
			&& !(low && blink_phase))
			c = low ? LOW_BAR_COLOUR : BAR_COLOUR;
		else
			c = BACKDROP_COLOUR;
		if (pause)
			c = {1'b0, c[15:12], 1'b0, c[10:6], 1'b0, c[4:1]};    // each channel halved.
		return c;
	endfunction

	// results are matched in order, checked at the falling edge.
	always @(negedge clk)
	begin : output_monitor
		int sent_index;
		logic [15:0] sent_colour;
		int sent_cycle;
		if (rst === 1'b0 && oled_valid === 1'b1)
		begin
			if (exp_index_q.size() == 0)
				report_failure($sformatf("oled_valid was high for index %0d with no pixel in flight",
					oled_index));
			else
			begin
				sent_index = exp_index_q.pop_front();
				sent_colour = exp_colour_q.pop_front();
				sent_cycle = exp_cycle_q.pop_front();
				check_value({test_name, " index"}, 32'(sent_index), 32'(oled_index));
				check_value($sformatf("%s colour of pixel %0d", test_name, sent_index),
					32'(sent_colour), 32'(oled_colour));
				check_value($sformatf("%s latency of pixel %0d", test_name, sent_index),
					32'd2, 32'(cycle_count - sent_cycle));
			end
		end
	end

	// ******************************
	// stimulus tasks
	// ******************************
	task automatic send_pixel(input int idx);
		@(posedge clk);
		#1;
		pixel_valid = 1'b1;
		pixel_index = INDEX_W'(idx);
		exp_index_q.push_back(idx);
		exp_colour_q.push_back(expected_colour(idx));
		exp_cycle_q.push_back(cycle_count);
		if (idx == 0)
			model_frames++;    // the DUT counts the frame after this pixel.
	endtask

	task automatic flush_pixels();
		int waited;
		@(posedge clk);
		#1;
		pixel_valid = 1'b0;
		waited = 0;
		while (exp_index_q.size() != 0)
		begin
			@(negedge clk);
			#1;
			waited++;
			if (waited > DRAIN_LIMIT)
				report_failure($sformatf("oled_valid never came for pixel %0d", exp_index_q[0]));
		end
	endtask

	task automatic load_level(input int value);
		@(posedge clk);
		#1;
		level_load = 1'b1;
		level_value = LEVEL_W'(value);
		model_level = (value > PANEL_WIDTH) ? PANEL_WIDTH : value;
		@(posedge clk);
		#1;
		level_load = 1'b0;
	endtask

	// ******************************
	// tests
	// ******************************
	task automatic test_after_reset();
		test_name = "after_reset";
		repeat (4)
		begin
			@(negedge clk);
			check_value("after_reset idle valid", 32'd0, 32'(oled_valid));
		end
		for (int col = 0; col < PANEL_WIDTH; col++)
			send_pixel(60 * PANEL_WIDTH + col);    // one full bar row, back to back.
		flush_pixels();
	endtask

	task automatic test_icon_pixels();
		test_name = "icon_pixels";
		send_pixel(2159);
		send_pixel(2730);
		send_pixel(3984);
		flush_pixels();
	endtask

	task automatic test_backdrop();
		test_name = "backdrop";
		send_pixel(0);
		send_pixel(100);
		send_pixel(2931);
		flush_pixels();
	endtask

	task automatic test_level_load();
		test_name = "level_load";
		load_level(40);
		send_pixel(59 * PANEL_WIDTH + 39);
		send_pixel(59 * PANEL_WIDTH + 40);
		flush_pixels();
		load_level(120);    // clamps to the panel width.
		send_pixel(59 * PANEL_WIDTH + 95);
		flush_pixels();
	endtask

	task automatic test_low_level();
		test_name = "low_level";
		load_level(10);
		send_pixel(60 * PANEL_WIDTH + 5);
		flush_pixels();
		repeat (BLINK_FRAMES)
			send_pixel(0);
		send_pixel(60 * PANEL_WIDTH + 5);
		flush_pixels();
		repeat (BLINK_FRAMES)
			send_pixel(0);
		send_pixel(60 * PANEL_WIDTH + 5);
		flush_pixels();
	endtask

	task automatic test_pause();
		test_name = "pause";
		@(posedge clk);
		#1;
		pause = 1'b1;
		send_pixel(2159);
		send_pixel(0);
		flush_pixels();
		@(posedge clk);
		#1;
		pause = 1'b0;
	endtask

	initial
	begin
		rst = 1'b1;
		pixel_valid = 1'b1;    // pixels offered during reset must not come out.
		pixel_index = '0;
		level_load = 1'b0;
		level_value = '0;
		pause = 1'b0;
		model_level = PANEL_WIDTH;
		model_frames = 0;
		test_name = "reset";
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		pixel_valid = 1'b0;
		test_after_reset();
		test_icon_pixels();
		test_backdrop();
		test_level_load();
		test_low_level();
		test_pause();
		$display("TEST OK");
		$finish;
	end

endmodule

/* vlog.f */
verilog/oled_pkg.sv
verilog/layer_if.sv
verilog/injury_icon_layer.sv
verilog/status_bar_layer.sv
verilog/pixel_compositor.sv
verilog/oled_overlay_top.sv
tests/oled_overlay_tb.sv

/* Makefile */
# Verilator build and run of the OLED overlay testbench.

VERILATOR ?= verilator
TOP ?= oled_overlay_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= TEST OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
